//--- common/cache_pkg.sv
// Cache package with address field positions, word, line and grant types
`default_nettype none

package cache_pkg;

	localparam int NUM_SETS = 8;
	localparam int NUM_WAYS = 2;

	// Word address layout: tag | index | offset | byte
	localparam int TAG_MSB = 15;
	localparam int TAG_LSB = 7;
	localparam int INDEX_MSB = 6;
	localparam int INDEX_LSB = 4;
	localparam int OFFSET_MSB = 3;
	localparam int OFFSET_LSB = 1;

	typedef logic [15:0] word_t;
	typedef logic [1:0] byte_en_t;
	typedef logic [TAG_MSB-TAG_LSB:0] tag_t;
	typedef logic [INDEX_MSB-INDEX_LSB:0] index_t;
	typedef logic [OFFSET_MSB-OFFSET_LSB:0] offset_t;

	// Eight words per line
	typedef logic [127:0] line_t;

	typedef enum logic
	{
		client_fetch = 1'b0,
		client_data = 1'b1
	} client_t;

endpackage

`default_nettype wire

//--- cache/way_array.sv
// Way array holding one entry per set, written on the clock edge and read combinationally
`timescale 1ns/1ps
`default_nettype none

module way_array #(
	parameter type entry_t = logic [7:0]
) (
	input wire logic clk,
	input wire logic write,
	input wire cache_pkg::index_t index,
	input wire entry_t wdata,
	output entry_t rdata
);

	entry_t mem [2**$bits(index)];

	always_ff @(posedge clk)
	begin
		if (write)
			mem[index] <= wdata;
	end

	assign rdata = mem[index];

endmodule

`default_nettype wire

//--- src/client_arbiter.sv
// Client arbiter granting the fetch or data port access to the shared cache
`timescale 1ns/1ps
`default_nettype none

module client_arbiter (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic if_req,
	input wire cache_pkg::word_t if_addr,
	output logic if_ack,
	output cache_pkg::word_t if_rdata,
	input wire logic dc_req,
	input wire logic dc_write,
	input wire cache_pkg::byte_en_t dc_byte_en,
	input wire cache_pkg::word_t dc_addr,
	input wire cache_pkg::word_t dc_wdata,
	output logic dc_ack,
	output cache_pkg::word_t dc_rdata,
	output logic cache_req,
	output logic cache_write,
	output cache_pkg::byte_en_t cache_byte_en,
	output cache_pkg::word_t cache_addr,
	output cache_pkg::word_t cache_wdata,
	input wire logic cache_ack,
	input wire cache_pkg::word_t cache_rdata
);
	import cache_pkg::*;

	client_t grant_q;
	logic busy_q;
	logic granted_req;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			grant_q <= client_fetch;
			busy_q <= 1'b0;
		end
		else if (!busy_q)
		begin
			// Data port wins a tie
			if (dc_req || if_req)
			begin
				busy_q <= 1'b1;
				grant_q <= dc_req ? client_data : client_fetch;
			end
		end
		else if (!granted_req && !cache_ack)
		begin
			busy_q <= 1'b0;
		end
	end

	always_comb
	begin
		if (grant_q == client_data)
		begin
			granted_req = dc_req;
			cache_write = dc_write;
			cache_byte_en = dc_byte_en;
			cache_addr = dc_addr;
			cache_wdata = dc_wdata;
		end
		else
		begin
			// Fetch only reads whole words
			granted_req = if_req;
			cache_write = 1'b0;
			cache_byte_en = 2'b11;
			cache_addr = if_addr;
			cache_wdata = '0;
		end
	end

	assign cache_req = busy_q & granted_req;

	assign if_ack = busy_q & (grant_q == client_fetch) & cache_ack;
	assign dc_ack = busy_q & (grant_q == client_data) & cache_ack;
	assign if_rdata = (grant_q == client_fetch) ? cache_rdata : '0;
	assign dc_rdata = (grant_q == client_data) ? cache_rdata : '0;

	// A new grant starts only once the previous ack has fallen
	ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(busy_q) |-> !cache_ack);

endmodule

`default_nettype wire

//--- cache/cache_datapath.sv
// Cache datapath with tag and line arrays, valid/dirty/LRU state, hit detection and byte merge
`timescale 1ns/1ps
`default_nettype none

module cache_datapath (
	input wire logic clk,
	input wire logic rst_n,
	input wire cache_pkg::word_t req_addr,
	input wire cache_pkg::word_t req_wdata,
	input wire cache_pkg::byte_en_t req_byte_en,
	input wire logic req_write,
	input wire logic lookup_en,
	input wire logic line_write,
	input wire logic line_from_mem,
	input wire logic meta_write,
	input wire logic set_dirty,
	input wire logic lru_update,
	input wire logic evict_sel,
	input wire cache_pkg::line_t pmem_rdata,
	output logic hit,
	output logic hit_way,
	output logic victim_dirty,
	output cache_pkg::word_t rdata,
	output cache_pkg::word_t pmem_addr,
	output cache_pkg::line_t pmem_wdata
);
	import cache_pkg::*;

	tag_t tag;
	index_t index;
	offset_t offset;

	tag_t tag_rd [2];
	line_t line_rd [2];
	logic [1:0] way_hit;

	logic [1:0][NUM_SETS-1:0] valid_q;
	logic [1:0][NUM_SETS-1:0] dirty_q;
	logic [NUM_SETS-1:0] lru_q;

	logic victim;
	logic write_way;
	word_t cur_word;
	word_t new_word;
	line_t merged_line;
	line_t line_wdata;

	assign tag = req_addr[TAG_MSB:TAG_LSB];
	assign index = req_addr[INDEX_MSB:INDEX_LSB];
	assign offset = req_addr[OFFSET_MSB:OFFSET_LSB];

	// LRU bit names the way to evict
	assign victim = lru_q[index];
	assign write_way = hit ? hit_way : victim;

	for (genvar w = 0; w < 2; w++)
	begin : g_way
		way_array #(.entry_t(tag_t)) i_tag (
			.clk(clk),
			.write(meta_write && (write_way == w)),
			.index(index),
			.wdata(tag),
			.rdata(tag_rd[w])
		);

		way_array #(.entry_t(line_t)) i_line (
			.clk(clk),
			.write(line_write && (write_way == w)),
			.index(index),
			.wdata(line_wdata),
			.rdata(line_rd[w])
		);

		assign way_hit[w] = valid_q[w][index] && (tag_rd[w] == tag);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
			hit <= 1'b0;
			hit_way <= 1'b0;
		end
		else
		begin
			if (lookup_en)
			begin
				hit <= |way_hit;
				hit_way <= way_hit[1];
			end
			// Refill clears dirty, store hit sets it
			if (meta_write)
			begin
				valid_q[write_way][index] <= 1'b1;
				dirty_q[write_way][index] <= set_dirty;
			end
			if (lru_update)
				lru_q[index] <= ~hit_way;
		end
	end

	// Store bytes into the addressed word of the hit line
	always_comb
	begin
		merged_line = line_rd[write_way];
		cur_word = merged_line[offset*$bits(word_t) +: $bits(word_t)];
		new_word = cur_word;
		for (int b = 0; b < 2; b++)
		begin
			if (req_byte_en[b] && req_write)
				new_word[b*8 +: 8] = req_wdata[b*8 +: 8];
		end
		merged_line[offset*$bits(word_t) +: $bits(word_t)] = new_word;
	end

	assign line_wdata = line_from_mem ? pmem_rdata : merged_line;

	assign rdata = line_rd[hit_way][offset*$bits(word_t) +: $bits(word_t)];

	assign victim_dirty = dirty_q[victim][index];
	assign pmem_wdata = line_rd[victim];
	assign pmem_addr = evict_sel ? {tag_rd[victim], index, 4'b0000} : {tag, index, 4'b0000};

	one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
		lookup_en |-> $countones(way_hit) < NUM_WAYS);

endmodule

`default_nettype wire

//--- cache/cache_control.sv
// Cache control FSM sequencing lookup, write-back, refill and the client ack
`timescale 1ns/1ps
`default_nettype none

module cache_control (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic cache_req,
	input wire logic req_write,
	input wire logic hit,
	input wire logic victim_dirty,
	input wire logic pmem_ack,
	output logic cache_ack,
	output logic lookup_en,
	output logic line_write,
	output logic line_from_mem,
	output logic meta_write,
	output logic set_dirty,
	output logic lru_update,
	output logic evict_sel,
	output logic pmem_req,
	output logic pmem_write
);

	typedef enum logic [2:0]
	{
		s_idle,
		s_lookup,
		s_wb,
		s_wb_rel,
		s_refill,
		s_refill_rel,
		s_ack
	} state_t;

	state_t state_q;
	state_t state_d;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= s_idle;
		else
			state_q <= state_d;
	end

	always_comb
	begin
		state_d = state_q;
		cache_ack = 1'b0;
		lookup_en = 1'b0;
		line_write = 1'b0;
		line_from_mem = 1'b0;
		meta_write = 1'b0;
		set_dirty = 1'b0;
		lru_update = 1'b0;
		evict_sel = 1'b0;
		pmem_req = 1'b0;
		pmem_write = 1'b0;
		case (state_q)
			s_idle:
			begin
				if (cache_req)
				begin
					lookup_en = 1'b1;
					state_d = s_lookup;
				end
			end
			s_lookup:
			begin
				if (hit)
				begin
					// Store hit merges bytes and marks the line dirty
					line_write = req_write;
					meta_write = req_write;
					set_dirty = req_write;
					lru_update = 1'b1;
					state_d = s_ack;
				end
				else if (victim_dirty)
					state_d = s_wb;
				else
					state_d = s_refill;
			end
			s_wb:
			begin
				pmem_req = 1'b1;
				pmem_write = 1'b1;
				evict_sel = 1'b1;
				if (pmem_ack)
					state_d = s_wb_rel;
			end
			s_wb_rel:
			begin
				if (!pmem_ack)
					state_d = s_refill;
			end
			s_refill:
			begin
				pmem_req = 1'b1;
				if (pmem_ack)
				begin
					line_write = 1'b1;
					line_from_mem = 1'b1;
					meta_write = 1'b1;
					state_d = s_refill_rel;
				end
			end
			s_refill_rel:
			begin
				// Replay the lookup, now a hit
				if (!pmem_ack)
				begin
					lookup_en = 1'b1;
					state_d = s_lookup;
				end
			end
			s_ack:
			begin
				cache_ack = 1'b1;
				if (!cache_req)
					state_d = s_idle;
			end
			default:
			begin
				state_d = s_idle;
			end
		endcase
	end

	pmem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_req && !pmem_ack |=> pmem_req && $stable(pmem_write));

endmodule

`default_nettype wire

//--- src/mem_subsystem.sv
// Memory subsystem top joining the client arbiter with the cache datapath and control
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic if_req,
	input wire cache_pkg::word_t if_addr,
	output logic if_ack,
	output cache_pkg::word_t if_rdata,
	input wire logic dc_req,
	input wire logic dc_write,
	input wire cache_pkg::byte_en_t dc_byte_en,
	input wire cache_pkg::word_t dc_addr,
	input wire cache_pkg::word_t dc_wdata,
	output logic dc_ack,
	output cache_pkg::word_t dc_rdata,
	output logic pmem_req,
	output logic pmem_write,
	output cache_pkg::word_t pmem_addr,
	output cache_pkg::line_t pmem_wdata,
	input wire logic pmem_ack,
	input wire cache_pkg::line_t pmem_rdata
);
	import cache_pkg::*;

	logic cache_req;
	logic cache_write;
	byte_en_t cache_byte_en;
	word_t cache_addr;
	word_t cache_wdata;
	logic cache_ack;
	word_t cache_rdata;

	logic lookup_en;
	logic line_write;
	logic line_from_mem;
	logic meta_write;
	logic set_dirty;
	logic lru_update;
	logic evict_sel;
	logic hit;
	logic victim_dirty;

	client_arbiter i_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_ack(if_ack),
		.if_rdata(if_rdata),
		.dc_req(dc_req),
		.dc_write(dc_write),
		.dc_byte_en(dc_byte_en),
		.dc_addr(dc_addr),
		.dc_wdata(dc_wdata),
		.dc_ack(dc_ack),
		.dc_rdata(dc_rdata),
		.cache_req(cache_req),
		.cache_write(cache_write),
		.cache_byte_en(cache_byte_en),
		.cache_addr(cache_addr),
		.cache_wdata(cache_wdata),
		.cache_ack(cache_ack),
		.cache_rdata(cache_rdata)
	);

	cache_datapath i_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.req_addr(cache_addr),
		.req_wdata(cache_wdata),
		.req_byte_en(cache_byte_en),
		.req_write(cache_write),
		.lookup_en(lookup_en),
		.line_write(line_write),
		.line_from_mem(line_from_mem),
		.meta_write(meta_write),
		.set_dirty(set_dirty),
		.lru_update(lru_update),
		.evict_sel(evict_sel),
		.pmem_rdata(pmem_rdata),
		.hit(hit),
		.hit_way(),
		.victim_dirty(victim_dirty),
		.rdata(cache_rdata),
		.pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata)
	);

	cache_control i_control (
		.clk(clk),
		.rst_n(rst_n),
		.cache_req(cache_req),
		.req_write(cache_write),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.pmem_ack(pmem_ack),
		.cache_ack(cache_ack),
		.lookup_en(lookup_en),
		.line_write(line_write),
		.line_from_mem(line_from_mem),
		.meta_write(meta_write),
		.set_dirty(set_dirty),
		.lru_update(lru_update),
		.evict_sel(evict_sel),
		.pmem_req(pmem_req),
		.pmem_write(pmem_write)
	);

endmodule

`default_nettype wire

//--- test/tb_phys_mem.sv
// Behavioral physical memory on the four-phase line port with read and write counters
`timescale 1ns/1ps
`default_nettype none

module tb_phys_mem (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic pmem_req,
	input wire logic pmem_write,
	input wire cache_pkg::word_t pmem_addr,
	input wire cache_pkg::line_t pmem_wdata,
	output logic pmem_ack,
	output cache_pkg::line_t pmem_rdata,
	output int read_count,
	output int write_count
);
	import cache_pkg::*;

	localparam int LATENCY = 3;
	localparam int NUM_WORDS = 32768;

	word_t mem [NUM_WORDS];
	logic [14:0] line_base;
	int wait_cnt;

	// Word at byte address a holds a ^ A5A5
	initial
	begin
		for (int i = 0; i < NUM_WORDS; i++)
			mem[i] = word_t'(i << 1) ^ 16'hA5A5;
	end

	assign line_base = {pmem_addr[15:4], 3'b000};

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pmem_ack <= 1'b0;
			pmem_rdata <= '0;
			wait_cnt <= 0;
			read_count <= 0;
			write_count <= 0;
		end
		else if (pmem_ack)
		begin
			// Release once the cache drops req
			if (!pmem_req)
				pmem_ack <= 1'b0;
		end
		else if (pmem_req)
		begin
			if (wait_cnt < LATENCY)
				wait_cnt <= wait_cnt + 1;
			else
			begin
				wait_cnt <= 0;
				pmem_ack <= 1'b1;
				if (pmem_write)
				begin
					for (int w = 0; w < 8; w++)
						mem[line_base + w] <= pmem_wdata[w*16 +: 16];
					write_count <= write_count + 1;
				end
				else
				begin
					for (int w = 0; w < 8; w++)
						pmem_rdata[w*16 +: 16] <= mem[line_base + w];
					read_count <= read_count + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- test/tb_mem_subsystem.sv
// Testbench for the memory subsystem with directed tests on both client ports
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
	import cache_pkg::*;

	localparam int TIMEOUT = 200;

	logic clk;
	logic rst_n;
	logic if_req;
	word_t if_addr;
	logic if_ack;
	word_t if_rdata;
	logic dc_req;
	logic dc_write;
	byte_en_t dc_byte_en;
	word_t dc_addr;
	word_t dc_wdata;
	logic dc_ack;
	word_t dc_rdata;
	logic pmem_req;
	logic pmem_write;
	word_t pmem_addr;
	line_t pmem_wdata;
	logic pmem_ack;
	line_t pmem_rdata;
	int mem_reads;
	int mem_writes;

	mem_subsystem i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.if_req(if_req),
		.if_addr(if_addr),
		.if_ack(if_ack),
		.if_rdata(if_rdata),
		.dc_req(dc_req),
		.dc_write(dc_write),
		.dc_byte_en(dc_byte_en),
		.dc_addr(dc_addr),
		.dc_wdata(dc_wdata),
		.dc_ack(dc_ack),
		.dc_rdata(dc_rdata),
		.pmem_req(pmem_req),
		.pmem_write(pmem_write),
		.pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata),
		.pmem_ack(pmem_ack),
		.pmem_rdata(pmem_rdata)
	);

	tb_phys_mem i_mem (
		.clk(clk),
		.rst_n(rst_n),
		.pmem_req(pmem_req),
		.pmem_write(pmem_write),
		.pmem_addr(pmem_addr),
		.pmem_wdata(pmem_wdata),
		.pmem_ack(pmem_ack),
		.pmem_rdata(pmem_rdata),
		.read_count(mem_reads),
		.write_count(mem_writes)
	);

	always #10 clk = ~clk;

	task automatic halt_with_failure();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected %0h, actual %0h", test, expected, actual);
			halt_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s did not change within %0d cycles", what, TIMEOUT);
		halt_with_failure();
	endtask

	function automatic word_t make_addr(input tag_t tag, input index_t index,
		input offset_t offset);
		return {tag, index, offset, 1'b0};
	endfunction

	// Initial memory contents
	function automatic word_t pattern(input word_t addr);
		return addr ^ 16'hA5A5;
	endfunction

	task automatic fetch_read(input word_t addr, output word_t rdata, output time ack_time);
		int cycles;
		@(posedge clk);
		#1;
		if_addr = addr;
		if_req = 1'b1;
		cycles = 0;
		while (!if_ack)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT)
				report_timeout("if_ack rise");
		end
		ack_time = $time;
		rdata = if_rdata;
		if_req = 1'b0;
		cycles = 0;
		while (if_ack)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT)
				report_timeout("if_ack fall");
		end
	endtask

	task automatic data_access(input logic write, input byte_en_t byte_en, input word_t addr,
		input word_t wdata, output word_t rdata, output time ack_time);
		int cycles;
		@(posedge clk);
		#1;
		dc_write = write;
		dc_byte_en = byte_en;
		dc_addr = addr;
		dc_wdata = wdata;
		dc_req = 1'b1;
		cycles = 0;
		while (!dc_ack)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT)
				report_timeout("dc_ack rise");
		end
		ack_time = $time;
		rdata = dc_rdata;
		dc_req = 1'b0;
		cycles = 0;
		while (dc_ack)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT)
				report_timeout("dc_ack fall");
		end
	endtask

	task automatic test_read_miss_hit();
		word_t addr;
		word_t rdata;
		time t;
		int reads;
		addr = make_addr(tag_t'($urandom), 3'd0, offset_t'($urandom));
		reads = mem_reads;
		fetch_read(addr, rdata, t);
		check_value("read_miss_hit miss data", pattern(addr), rdata);
		check_value("read_miss_hit miss reads", reads + 1, mem_reads);
		fetch_read(addr, rdata, t);
		check_value("read_miss_hit hit data", pattern(addr), rdata);
		check_value("read_miss_hit hit reads", reads + 1, mem_reads);
	endtask

	task automatic test_byte_stores();
		word_t addr;
		word_t rdata;
		time t;
		addr = make_addr(tag_t'($urandom), 3'd1, offset_t'($urandom % 7));
		data_access(1'b1, 2'b11, addr, 16'h1234, rdata, t);
		data_access(1'b1, 2'b10, addr, 16'hABCD, rdata, t);
		data_access(1'b0, 2'b11, addr, 16'h0000, rdata, t);
		check_value("byte_stores high byte", 16'hAB34, rdata);
		data_access(1'b1, 2'b01, addr, 16'h55EF, rdata, t);
		data_access(1'b0, 2'b11, addr, 16'h0000, rdata, t);
		check_value("byte_stores low byte", 16'hABEF, rdata);
		// Next word in the line stays untouched
		data_access(1'b0, 2'b11, addr + 16'd2, 16'h0000, rdata, t);
		check_value("byte_stores neighbor", pattern(addr + 16'd2), rdata);
	endtask

	task automatic test_dirty_write_back();
		tag_t tag_a;
		tag_t tag_b;
		tag_t tag_c;
		word_t addr_a;
		word_t addr_c;
		word_t rdata;
		time t;
		int writes;
		tag_a = tag_t'($urandom);
		tag_b = tag_a + tag_t'(1 + $urandom % 100);
		tag_c = tag_b + tag_t'(1 + $urandom % 100);
		addr_a = make_addr(tag_a, 3'd2, 3'd5);
		addr_c = make_addr(tag_c, 3'd2, 3'd0);
		writes = mem_writes;
		data_access(1'b1, 2'b11, addr_a, 16'hC0DE, rdata, t);
		fetch_read(make_addr(tag_b, 3'd2, 3'd0), rdata, t);
		fetch_read(addr_c, rdata, t);
		check_value("dirty_write_back evict data", pattern(addr_c), rdata);
		check_value("dirty_write_back writes", writes + 1, mem_writes);
		check_value("dirty_write_back memory", 16'hC0DE, i_mem.mem[addr_a[15:1]]);
		data_access(1'b0, 2'b11, addr_a, 16'h0000, rdata, t);
		check_value("dirty_write_back reread", 16'hC0DE, rdata);
	endtask

	task automatic test_lru();
		word_t addr_a;
		word_t addr_b;
		word_t addr_c;
		word_t rdata;
		time t;
		int reads;
		addr_a = make_addr(tag_t'($urandom), 3'd3, 3'd1);
		addr_b = make_addr(addr_a[TAG_MSB:TAG_LSB] + tag_t'(1 + $urandom % 100), 3'd3, 3'd2);
		addr_c = make_addr(addr_b[TAG_MSB:TAG_LSB] + tag_t'(1 + $urandom % 100), 3'd3, 3'd3);
		fetch_read(addr_a, rdata, t);
		fetch_read(addr_b, rdata, t);
		fetch_read(addr_a, rdata, t);
		fetch_read(addr_c, rdata, t);
		reads = mem_reads;
		fetch_read(addr_a, rdata, t);
		check_value("lru keep data", pattern(addr_a), rdata);
		check_value("lru keep reads", reads, mem_reads);
		fetch_read(addr_b, rdata, t);
		check_value("lru evicted data", pattern(addr_b), rdata);
		check_value("lru evicted reads", reads + 1, mem_reads);
	endtask

	task automatic test_arbitration();
		word_t addr_i;
		word_t addr_d;
		word_t rdata_i;
		word_t rdata_d;
		time t_i;
		time t_d;
		addr_i = make_addr(tag_t'($urandom), 3'd5, offset_t'($urandom));
		addr_d = make_addr(tag_t'($urandom), 3'd4, offset_t'($urandom));
		fork
			fetch_read(addr_i, rdata_i, t_i);
			data_access(1'b0, 2'b11, addr_d, 16'h0000, rdata_d, t_d);
		join
		check_value("arbitration fetch data", pattern(addr_i), rdata_i);
		check_value("arbitration data data", pattern(addr_d), rdata_d);
		check_value("arbitration order", 1, t_d < t_i);
	endtask

	// Acks must never overlap
	always @(negedge clk)
	begin
		if (rst_n === 1'b1)
			check_value("ack_overlap", 0, if_ack & dc_ack);
	end

	initial
	begin
		void'($urandom(54175));
		clk = 1'b0;
		rst_n = 1'b0;
		if_req = 1'b0;
		if_addr = '0;
		dc_req = 1'b0;
		dc_write = 1'b0;
		dc_byte_en = '0;
		dc_addr = '0;
		dc_wdata = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_read_miss_hit();
		test_byte_stores();
		test_dirty_write_back();
		test_lru();
		test_arbitration();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/cache_pkg.sv
cache/way_array.sv
src/client_arbiter.sv
cache/cache_datapath.sv
cache/cache_control.sv
src/mem_subsystem.sv
test/tb_phys_mem.sv
test/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - common/cache_pkg.sv
  - cache/way_array.sv
  - src/client_arbiter.sv
  - cache/cache_datapath.sv
  - cache/cache_control.sv
  - src/mem_subsystem.sv
  - target: test
    files:
      - test/tb_phys_mem.sv
      - test/tb_mem_subsystem.sv
